/* include/sdram_settings.svh */
// ##################################################
// SDRAM subsystem settings
// widths, latency, burst size and init delay
// ##################################################
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// pin bus widths
`define SDRAM_DATA_W 16
`define SDRAM_ADDR_W 13
`define SDRAM_BANK_W 2

// stored array size, shrunk for simulation
`define SDRAM_ROW_W 4
`define SDRAM_COL_W 6

// CAS latency in clocks, goes into the mode word
`define SDRAM_CAS_LAT 2

// words per burst, literal count in the mode word
`define SDRAM_BURST_LEN 4

// clocks from reset release to LOAD MODE
`define SDRAM_INIT_CYCLES 8

`endif

/* hdl/sdram_pkg.sv */
// ##################################################
// SDRAM subsystem types
// pin command, address views, burst and request
// ##################################################
`default_nettype none

`include "sdram_settings.svh"

package sdram_pkg;

    typedef struct packed {
        logic cs;                                  // all active low
        logic ras;
        logic cas;
        logic we;
    } sdram_cmd_t;

    localparam sdram_cmd_t cmd_nop       = '{cs: 1'b1, ras: 1'b1, cas: 1'b1, we: 1'b1};
    localparam sdram_cmd_t cmd_active    = '{cs: 1'b0, ras: 1'b0, cas: 1'b1, we: 1'b1};
    localparam sdram_cmd_t cmd_read      = '{cs: 1'b0, ras: 1'b1, cas: 1'b0, we: 1'b1};
    localparam sdram_cmd_t cmd_write     = '{cs: 1'b0, ras: 1'b1, cas: 1'b0, we: 1'b0};
    localparam sdram_cmd_t cmd_load_mode = '{cs: 1'b0, ras: 1'b0, cas: 1'b0, we: 1'b0};

    typedef struct packed {
        logic [2:0] reserved;                      // a12..a10
        logic       wb_mode;
        logic [1:0] op_mode;
        logic [2:0] cas_latency;
        logic       burst_type;
        logic [2:0] burst_len;                     // literal word count
    } sdram_mode_t;

    typedef struct packed {
        logic       spare;
        logic       col_hi;                        // a11
        logic       auto_pre;                      // a10, not used
        logic [9:0] col_lo;
    } sdram_col_t;

    typedef union packed {
        sdram_mode_t              mode;
        sdram_col_t               col;
        logic [`SDRAM_ADDR_W-1:0] row;
    } sdram_addr_u;

    typedef logic [`SDRAM_BURST_LEN-1:0][`SDRAM_DATA_W-1:0] sdram_burst_t;

    typedef struct packed {
        logic                     write;
        logic [`SDRAM_BANK_W-1:0] bank;
        logic [`SDRAM_ROW_W-1:0]  row;
        logic [`SDRAM_COL_W-1:0]  col;             // start column
        logic [1:0]               byte_mask;       // high masks a lane
        sdram_burst_t             wdata;
    } host_req_t;

endpackage

`default_nettype wire

/* hdl/sdram_model.sv */
// ##################################################
// Behavioural SDRAM device model
// decodes pin commands, one open row, banked array
// ##################################################
`default_nettype none

`include "sdram_settings.svh"

module sdram_model (
    input  logic                      clk,
    input  logic                      cke,
    input  sdram_pkg::sdram_cmd_t     cmd,
    input  sdram_pkg::sdram_addr_u    a,
    input  logic [`SDRAM_BANK_W-1:0]  ba,
    input  logic [1:0]                dqm,
    inout  wire  [`SDRAM_DATA_W-1:0]  dq
);
    import sdram_pkg::*;

    localparam int bank_n = 2 ** `SDRAM_BANK_W;
    localparam int row_n  = 2 ** `SDRAM_ROW_W;
    localparam int col_n  = 2 ** `SDRAM_COL_W;

    typedef enum logic [1:0] {
        rd_idle,
        rd_lat,
        rd_out
    } rd_state_t;

    logic [2:0]               cas_lat;
    logic [2:0]               burst_len;
    logic [`SDRAM_BANK_W-1:0] bank_q;
    logic [`SDRAM_ROW_W-1:0]  row_q;
    logic [`SDRAM_COL_W-1:0]  col_q;
    rd_state_t                rd_state;
    logic [2:0]               rd_cnt;
    logic [2:0]               wr_left;
    logic                     out_en;

    logic [`SDRAM_DATA_W-1:0] mem [bank_n][row_n][col_n];

    logic                     active_cmd;
    logic                     read_cmd;
    logic                     write_cmd;
    logic                     loadm_cmd;
    logic [10:0]              col_full;
    logic [`SDRAM_COL_W-1:0]  col_start;
    logic [`SDRAM_COL_W-1:0]  wr_col;
    logic                     wr_en;

    assign active_cmd = (cmd == cmd_active);
    assign read_cmd   = (cmd == cmd_read) && (ba == bank_q);    // open bank only
    assign write_cmd  = (cmd == cmd_write) && (ba == bank_q);
    assign loadm_cmd  = (cmd == cmd_load_mode);

    assign col_full  = {a.col.col_hi, a.col.col_lo};
    assign col_start = col_full[`SDRAM_COL_W-1:0];

    assign wr_en  = write_cmd || (wr_left != 3'd0);
    assign wr_col = write_cmd ? col_start : col_q;

    assign dq = out_en ? mem[bank_q][row_q][col_q] : {`SDRAM_DATA_W{1'bz}};

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            cas_lat   <= 3'd0;                          // set by LOAD MODE
            burst_len <= 3'd0;
        end else if (loadm_cmd) begin
            cas_lat   <= a.mode.cas_latency;
            burst_len <= a.mode.burst_len;
        end
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            bank_q <= '0;
            row_q  <= '0;
        end else if (active_cmd) begin
            bank_q <= ba;
            row_q  <= a.row[`SDRAM_ROW_W-1:0];           // upper row bits not stored
        end
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            rd_state <= rd_idle;
            rd_cnt   <= 3'd0;
            wr_left  <= 3'd0;
            out_en   <= 1'b0;
            col_q    <= '0;
        end else begin
            if (write_cmd) begin
                col_q   <= col_start + 1'b1;            // first word stored at W
                wr_left <= burst_len - 3'd1;
            end else if (wr_left != 3'd0) begin
                col_q   <= col_q + 1'b1;                // wraps within the row
                wr_left <= wr_left - 3'd1;
            end

            case (rd_state)
                rd_idle: begin
                    if (read_cmd) begin
                        col_q    <= col_start;
                        rd_cnt   <= 3'd1;
                        rd_state <= rd_lat;
                    end
                end
                rd_lat: begin
                    if (rd_cnt == cas_lat) begin
                        out_en   <= 1'b1;
                        rd_cnt   <= 3'd1;
                        rd_state <= rd_out;
                    end else begin
                        rd_cnt <= rd_cnt + 3'd1;
                    end
                end
                rd_out: begin
                    col_q <= col_q + 1'b1;
                    if (rd_cnt == burst_len) begin
                        out_en   <= 1'b0;               // release dq
                        rd_state <= rd_idle;
                    end else begin
                        rd_cnt <= rd_cnt + 3'd1;
                    end
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (!dqm[0]) begin
                mem[bank_q][row_q][wr_col][7:0] <= dq[7:0];
            end
            if (!dqm[1]) begin
                mem[bank_q][row_q][wr_col][15:8] <= dq[15:8];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sdram_ctrl.sv */
// ##################################################
// SDRAM host controller
// loads the mode register, then runs
// ACTIVE plus READ or WRITE bursts per request
// ##################################################
`default_nettype none

`include "sdram_settings.svh"

module sdram_ctrl (
    input  logic                      clk,
    input  logic                      cke,
    input  logic                      req,
    input  sdram_pkg::host_req_t      req_info,
    output logic                      busy,
    output logic                      rd_valid,
    output logic [`SDRAM_DATA_W-1:0]  rd_data,
    output sdram_pkg::sdram_cmd_t     cmd,
    output sdram_pkg::sdram_addr_u    a,
    output logic [`SDRAM_BANK_W-1:0]  ba,
    output logic [1:0]                dqm,
    inout  wire  [`SDRAM_DATA_W-1:0]  dq
);
    import sdram_pkg::*;

    localparam int cnt_w =
        $clog2(`SDRAM_INIT_CYCLES + `SDRAM_CAS_LAT + `SDRAM_BURST_LEN + 1);

    localparam logic [cnt_w-1:0] init_last = cnt_w'(`SDRAM_INIT_CYCLES - 1);
    localparam logic [cnt_w-1:0] wr_last   = cnt_w'(`SDRAM_BURST_LEN - 1);
    localparam logic [cnt_w-1:0] wr_done   = cnt_w'(`SDRAM_BURST_LEN);
    localparam logic [cnt_w-1:0] rd_first  = cnt_w'(`SDRAM_CAS_LAT);
    localparam logic [cnt_w-1:0] rd_done   = cnt_w'(`SDRAM_CAS_LAT + `SDRAM_BURST_LEN);

    typedef enum logic [2:0] {
        st_init,
        st_mode,
        st_idle,
        st_act,
        st_write,
        st_read
    } state_t;

    state_t           state;
    logic [cnt_w-1:0] cnt;
    logic             dq_oe;
    host_req_t        req_q;
    sdram_addr_u      mode_word;
    sdram_addr_u      col_word;
    sdram_addr_u      row_word;
    logic             accept;
    logic             capture;

    assign accept  = req && !busy;
    assign capture = (state == st_read) && (cnt > rd_first);   // CL window

    always_comb begin
        mode_word = '0;
        mode_word.mode.cas_latency = 3'(`SDRAM_CAS_LAT);
        mode_word.mode.burst_len   = 3'(`SDRAM_BURST_LEN);
        col_word = '0;
        col_word.col.col_lo[`SDRAM_COL_W-1:0] = req_q.col;
        row_word = '0;
        row_word.row[`SDRAM_ROW_W-1:0] = req_info.row;          // ACTIVE goes out at accept
    end

    assign dq = dq_oe ? req_q.wdata[0] : {`SDRAM_DATA_W{1'bz}};

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            state    <= st_init;
            cnt      <= '0;
            busy     <= 1'b1;
            rd_valid <= 1'b0;
            dq_oe    <= 1'b0;
            cmd      <= cmd_nop;
            a        <= '0;
            ba       <= '0;
            dqm      <= '0;
        end else begin
            cmd      <= cmd_nop;                       // commands last one cycle
            rd_valid <= capture;
            cnt      <= cnt + 1'b1;
            case (state)
                st_init: begin
                    if (cnt == init_last) begin
                        cmd   <= cmd_load_mode;
                        a     <= mode_word;
                        state <= st_mode;
                    end
                end
                st_mode: begin
                    busy  <= 1'b0;
                    state <= st_idle;
                end
                st_idle: begin
                    cnt <= '0;
                    if (accept) begin
                        cmd   <= cmd_active;
                        a     <= row_word;
                        ba    <= req_info.bank;
                        busy  <= 1'b1;
                        state <= st_act;
                    end
                end
                st_act: begin
                    cnt <= '0;
                    a   <= col_word;
                    if (req_q.write) begin
                        cmd   <= cmd_write;
                        dqm   <= req_q.byte_mask;
                        dq_oe <= 1'b1;                 // word 0 with the command
                        state <= st_write;
                    end else begin
                        cmd   <= cmd_read;
                        dqm   <= '0;
                        state <= st_read;
                    end
                end
                st_write: begin
                    if (cnt == wr_last) begin
                        dq_oe <= 1'b0;
                        dqm   <= '0;
                    end
                    if (cnt == wr_done) begin
                        busy  <= 1'b0;
                        state <= st_idle;
                    end
                end
                st_read: begin
                    if (cnt == rd_done) begin
                        busy  <= 1'b0;                 // with the last rd_valid
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_info;
        end else if (dq_oe) begin
            req_q.wdata <= sdram_burst_t'({{`SDRAM_DATA_W{1'b0}},
                                           req_q.wdata[`SDRAM_BURST_LEN-1:1]});
        end
        if (capture) begin
            rd_data <= dq;
        end
    end

endmodule

`default_nettype wire

/* hdl/sdram_subsys.sv */
// ##################################################
// SDRAM subsystem top
// host controller joined to the device model
// ##################################################
`default_nettype none

`include "sdram_settings.svh"

module sdram_subsys (
    input  logic                      clk,
    input  logic                      cke,
    input  logic                      req,
    input  sdram_pkg::host_req_t      req_info,
    output logic                      busy,
    output logic                      rd_valid,
    output logic [`SDRAM_DATA_W-1:0]  rd_data
);
    import sdram_pkg::*;

    sdram_cmd_t               cmd;
    sdram_addr_u              a;
    logic [`SDRAM_BANK_W-1:0] ba;
    logic [1:0]               dqm;
    wire  [`SDRAM_DATA_W-1:0] dq;          // shared, tri-stated at both ends

    sdram_ctrl i_ctrl (
        .clk      (clk),
        .cke      (cke),
        .req      (req),
        .req_info (req_info),
        .busy     (busy),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .cmd      (cmd),
        .a        (a),
        .ba       (ba),
        .dqm      (dqm),
        .dq       (dq)
    );

    sdram_model i_model (
        .clk (clk),
        .cke (cke),
        .cmd (cmd),
        .a   (a),
        .ba  (ba),
        .dqm (dqm),
        .dq  (dq)
    );

endmodule

`default_nettype wire

/* bench/sdram_subsys_tb.sv */
// ##################################################
// SDRAM subsystem testbench
// table of host bursts checked against a shadow array
// ##################################################
`default_nettype none

`include "sdram_settings.svh"

module sdram_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import sdram_pkg::*;

    localparam int bl           = `SDRAM_BURST_LEN;
    localparam int col_n        = 2 ** `SDRAM_COL_W;
    localparam int n_entries    = 18;
    localparam int period       = 100;
    localparam int entry_cycles = 4 + `SDRAM_CAS_LAT + `SDRAM_BURST_LEN;
    localparam int wait_limit   = 2 * entry_cycles;
    localparam int init_limit   = `SDRAM_INIT_CYCLES + 4;
    localparam int watchdog_ns  = (`SDRAM_INIT_CYCLES + n_entries * entry_cycles) * 2 * period;

    typedef struct packed {
        logic                     write;
        logic [`SDRAM_BANK_W-1:0] bank;
        logic [`SDRAM_ROW_W-1:0]  row;
        logic [`SDRAM_COL_W-1:0]  col;
        logic [1:0]               byte_mask;
        logic                     dup;         // second req while busy
        logic                     rand_fill;
        sdram_burst_t             wdata;       // word 0 in the low bits
    } entry_t;

    // write bank row col mask dup rand wdata
    entry_t stim [n_entries] = '{
        '{1'b1, 2'd0, 4'd1, 6'd8,  2'b00, 1'b0, 1'b0, 64'h4444_3333_2222_1111},
        '{1'b0, 2'd0, 4'd1, 6'd8,  2'b00, 1'b0, 1'b0, 64'h0},
        '{1'b1, 2'd0, 4'd1, 6'd8,  2'b01, 1'b0, 1'b0, 64'haaaa_bbbb_cccc_dddd},
        '{1'b0, 2'd0, 4'd1, 6'd8,  2'b00, 1'b0, 1'b0, 64'h0},
        '{1'b1, 2'd0, 4'd1, 6'd8,  2'b10, 1'b0, 1'b1, 64'h0},
        '{1'b0, 2'd0, 4'd1, 6'd8,  2'b00, 1'b0, 1'b0, 64'h0},
        '{1'b1, 2'd2, 4'd5, 6'd8,  2'b00, 1'b0, 1'b1, 64'h0},
        '{1'b1, 2'd0, 4'd6, 6'd8,  2'b00, 1'b0, 1'b1, 64'h0},
        '{1'b0, 2'd0, 4'd1, 6'd8,  2'b00, 1'b0, 1'b0, 64'h0},
        '{1'b0, 2'd2, 4'd5, 6'd8,  2'b00, 1'b0, 1'b0, 64'h0},
        '{1'b0, 2'd0, 4'd6, 6'd8,  2'b00, 1'b0, 1'b0, 64'h0},
        '{1'b1, 2'd1, 4'd3, 6'd0,  2'b00, 1'b0, 1'b1, 64'h0},
        '{1'b1, 2'd1, 4'd3, 6'd62, 2'b00, 1'b0, 1'b1, 64'h0},   // wraps to col 0
        '{1'b0, 2'd1, 4'd3, 6'd62, 2'b00, 1'b0, 1'b0, 64'h0},
        '{1'b0, 2'd1, 4'd3, 6'd0,  2'b00, 1'b0, 1'b0, 64'h0},
        '{1'b1, 2'd3, 4'd2, 6'd16, 2'b00, 1'b1, 1'b1, 64'h0},
        '{1'b0, 2'd3, 4'd2, 6'd16, 2'b00, 1'b1, 1'b0, 64'h0},
        '{1'b0, 2'd3, 4'd2, 6'd16, 2'b00, 1'b0, 1'b0, 64'h0}
    };

    logic                     clk;
    logic                     cke;
    logic                     req;
    host_req_t                req_info;
    logic                     busy;
    logic                     rd_valid;
    logic [`SDRAM_DATA_W-1:0] rd_data;

    logic [`SDRAM_DATA_W-1:0] shadow [2 ** `SDRAM_BANK_W][2 ** `SDRAM_ROW_W][col_n];
    int                       errors;
    int                       entries_ok;
    int                       entries_bad;

    sdram_subsys i_dut (
        .clk      (clk),
        .cke      (cke),
        .req      (req),
        .req_info (req_info),
        .busy     (busy),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    always #(period / 2) clk = ~clk;

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("Test failed");
        $finish;
    end

    task automatic wait_idle(output logic ok);
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        ok = !busy;
    endtask

    // masked lanes keep the old value, columns wrap in the row
    function automatic void shadow_write(input entry_t e);
        int c;
        for (int i = 0; i < bl; i++) begin
            c = (int'(e.col) + i) % col_n;
            if (!e.byte_mask[0]) begin
                shadow[e.bank][e.row][c][7:0] = e.wdata[i][7:0];
            end
            if (!e.byte_mask[1]) begin
                shadow[e.bank][e.row][c][15:8] = e.wdata[i][15:8];
            end
        end
    endfunction

    task automatic run_entry(input entry_t e, input int idx);
        host_req_t                info;
        logic [`SDRAM_DATA_W-1:0] got [bl];
        logic [`SDRAM_DATA_W-1:0] exp_word;
        logic                     ok;
        logic                     done;
        int                       cycles;
        int                       nwords;
        int                       errs_in;

        errs_in        = errors;
        info.write     = e.write;
        info.bank      = e.bank;
        info.row       = e.row;
        info.col       = e.col;
        info.byte_mask = e.byte_mask;
        info.wdata     = e.wdata;
        wait_idle(ok);
        assert (ok) else begin
            $display("busy stayed high before entry %0d could start", idx);
            errors++;
        end
        req      = 1'b1;
        req_info = info;
        if (e.write) begin
            shadow_write(e);
        end
        cycles = 0;
        nwords = 0;
        done   = 1'b0;
        while (!done && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
            req = e.dup && (cycles == 2);         // must be ignored
            if (req) begin
                req_info.wdata     = ~info.wdata;
                req_info.byte_mask = 2'b00;
            end
            if (rd_valid) begin
                if (nwords < bl) begin
                    got[nwords] = rd_data;
                end
                nwords++;
            end
            done = !busy;
        end
        assert (done) else begin
            $display("busy did not fall within %0d cycles in entry %0d", wait_limit, idx);
            errors++;
        end
        if (e.write) begin
            assert (nwords == 0) else begin
                $display("write entry %0d gave %0d rd_valid pulses", idx, nwords);
                errors++;
            end
        end else begin
            assert (nwords == bl) else begin
                $display("read entry %0d gave %0d rd_valid pulses, not %0d", idx, nwords, bl);
                errors++;
            end
            for (int i = 0; i < bl && i < nwords; i++) begin
                exp_word = shadow[e.bank][e.row][(int'(e.col) + i) % col_n];
                assert (got[i] === exp_word) else begin
                    $display("Fail rd_data entry %0d word %0d: expected %h, got %h",
                             idx, i, exp_word, got[i]);
                    errors++;
                end
            end
        end
        repeat (2) begin
            @(negedge clk);
            assert (!rd_valid) else begin
                $display("extra rd_valid pulse after entry %0d", idx);
                errors++;
            end
            assert (!busy) else begin
                $display("busy rose again after entry %0d with no request taken", idx);
                errors++;
            end
        end
        if (errors == errs_in) begin
            entries_ok++;
            $display("entry %0d %s bank %0d row %0d col %0d: ok",
                     idx, e.write ? "write" : "read", e.bank, e.row, e.col);
        end else begin
            entries_bad++;
            $display("entry %0d %s bank %0d row %0d col %0d: %0d errors",
                     idx, e.write ? "write" : "read", e.bank, e.row, e.col, errors - errs_in);
        end
    endtask

    initial begin
        entry_t e;
        int     n;

        clk         = 1'b0;
        cke         = 1'b0;
        req         = 1'b0;
        req_info    = '0;
        errors      = 0;
        entries_ok  = 0;
        entries_bad = 0;
        void'($urandom(32'hb8d2));
        repeat (8) @(negedge clk);
        cke = 1'b1;
        assert (busy === 1'b1) else begin
            $display("Fail busy after reset: expected %h, got %h", 1'b1, busy);
            errors++;
        end
        assert (rd_valid === 1'b0) else begin
            $display("Fail rd_valid after reset: expected %h, got %h", 1'b0, rd_valid);
            errors++;
        end
        n = 0;
        while (busy !== 1'b0 && n < init_limit) begin
            @(negedge clk);
            n++;
        end
        assert (busy === 1'b0) else begin
            $display("busy did not fall within %0d cycles of reset release", init_limit);
            errors++;
        end

        for (int k = 0; k < n_entries; k++) begin
            e = stim[k];
            if (e.rand_fill) begin
                for (int i = 0; i < bl; i++) begin
                    e.wdata[i] = 16'($urandom);
                end
            end
            run_entry(e, k);
        end

        $display("entries: %0d passed, %0d failed, %0d errors",
                 entries_ok, entries_bad, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sdram_subsys.f */
+incdir+include
hdl/sdram_pkg.sv
hdl/sdram_model.sv
hdl/sdram_ctrl.sv
hdl/sdram_subsys.sv
bench/sdram_subsys_tb.sv

/* Bender.yml */
package:
  name: sdram_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/sdram_pkg.sv
      - hdl/sdram_model.sv
      - hdl/sdram_ctrl.sv
      - hdl/sdram_subsys.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/sdram_subsys_tb.sv
